//--- include/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Entries in the circular instruction queue
`define FETCH_QUEUE_DEPTH 8

// 32-bit words delivered per instruction cache line
`define FETCH_LINE_WORDS 4

// Instructions handed to decode per cycle, and the number of predecoders
`define FETCH_ISSUE_WIDTH 2

`endif

//--- source/fetch_types_pkg.sv
`default_nettype none

`include "fetch_settings.svh"

package fetch_types_pkg;

    // One MIPS32 instruction
    typedef logic [31:0] word_t;

    // Byte address of an instruction
    typedef logic [31:0] pc_t;

    // Cache line with word 0 in the low bits
    typedef logic [`FETCH_LINE_WORDS*32-1:0] line_t;

    // Queue index, wraps on overflow
    typedef logic [$clog2(`FETCH_QUEUE_DEPTH)-1:0] qptr_t;

    // Occupancy needs one more bit than the index so that a full queue is distinct
    typedef logic [$clog2(`FETCH_QUEUE_DEPTH):0] qcount_t;

    // Instructions sent to decode in one cycle
    typedef logic [$clog2(`FETCH_ISSUE_WIDTH):0] issue_num_t;

endpackage

`default_nettype wire

//--- source/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [4:0] reg_t;

    ////////////////////////////////////////
    // Primary opcodes, bits 31:26
    ////////////////////////////////////////

    localparam opcode_t SPECIAL = 6'b000000;
    localparam opcode_t REGIMM  = 6'b000001;
    localparam opcode_t J       = 6'b000010;
    localparam opcode_t JAL     = 6'b000011;
    localparam opcode_t BEQ     = 6'b000100;
    localparam opcode_t BNE     = 6'b000101;
    localparam opcode_t BLEZ    = 6'b000110;
    localparam opcode_t BGTZ    = 6'b000111;

    // Function field of SPECIAL, bits 5:0
    localparam funct_t JR   = 6'b001000;
    localparam funct_t JALR = 6'b001001;

    // The rt field selects the REGIMM branch, bits 20:16
    localparam reg_t BLTZ   = 5'b00000;
    localparam reg_t BGEZ   = 5'b00001;
    localparam reg_t BLTZAL = 5'b10000;
    localparam reg_t BGEZAL = 5'b10001;

    ////////////////////////////////////////
    // Control-transfer classes
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        none,
        cond_branch,
        jump,
        jump_reg
    } br_class_t;

endpackage

`default_nettype wire

//--- source/fetch_slot_if.sv
`default_nettype none

interface fetch_slot_if;
    import fetch_types_pkg::*;

    logic  present;
    word_t inst;
    pc_t   pc;
    // Set when the instruction is followed by a delay slot
    logic  br_op;

    modport queue (
        output present, inst, pc
    );

    modport predecode (
        input  inst,
        output br_op
    );

    modport select (
        input present, inst, pc, br_op
    );

endinterface

`default_nettype wire

//--- source/fetch_queue.sv
`default_nettype none

`include "fetch_settings.svh"

module fetch_queue (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        line_valid,
    input  fetch_types_pkg::pc_t        line_pc,
    input  fetch_types_pkg::line_t      line_data,
    output logic                        line_ready,
    input  fetch_types_pkg::issue_num_t pop_num,
    fetch_slot_if.queue                 slot0,
    fetch_slot_if.queue                 slot1
);
    import fetch_types_pkg::*;

    localparam int word_bits = $clog2(`FETCH_LINE_WORDS);

    word_t   entry_inst [`FETCH_QUEUE_DEPTH];
    pc_t     entry_pc   [`FETCH_QUEUE_DEPTH];
    qptr_t   head;
    qptr_t   tail;
    qcount_t count;

    logic                 push;
    logic [word_bits-1:0] first_word;
    qcount_t              push_num;
    logic                 wr_en   [`FETCH_LINE_WORDS];
    word_t                wr_inst [`FETCH_LINE_WORDS];
    pc_t                  wr_pc   [`FETCH_LINE_WORDS];

    ////////////////////////////////////////
    // Line intake
    ////////////////////////////////////////

    // Room for a whole line, judged before this cycle's pop
    assign line_ready = count <= qcount_t'(`FETCH_QUEUE_DEPTH - `FETCH_LINE_WORDS);

    assign push       = line_valid && line_ready && !flush;
    assign first_word = line_pc[word_bits+1:2];
    assign push_num   = qcount_t'(`FETCH_LINE_WORDS) - qcount_t'(first_word);

    // Lane i carries word first_word+i of the line
    for (genvar i = 0; i < `FETCH_LINE_WORDS; i++) begin : g_lane
        logic [word_bits-1:0] sel;

        assign sel        = first_word + word_bits'(i);
        assign wr_en[i]   = push && (qcount_t'(i) < push_num);
        assign wr_inst[i] = line_data[sel*32 +: 32];
        assign wr_pc[i]   = {line_pc[31:word_bits+2], sel, 2'b00};
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `FETCH_LINE_WORDS; i++) begin
            if (wr_en[i]) begin
                entry_inst[tail + qptr_t'(i)] <= wr_inst[i];
                entry_pc[tail + qptr_t'(i)]   <= wr_pc[i];
            end
        end
    end

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head <= head + qptr_t'(pop_num);
            if (push) begin
                tail <= tail + qptr_t'(push_num);
            end
            // The selector never pops more than the head slots hold
            count <= count + (push ? push_num : qcount_t'(0)) - qcount_t'(pop_num);
        end
    end

    ////////////////////////////////////////
    // Head slots
    ////////////////////////////////////////

    assign slot0.present = count != qcount_t'(0);
    assign slot0.inst    = entry_inst[head];
    assign slot0.pc      = entry_pc[head];

    assign slot1.present = count > qcount_t'(1);
    assign slot1.inst    = entry_inst[head + qptr_t'(1)];
    assign slot1.pc      = entry_pc[head + qptr_t'(1)];

endmodule

`default_nettype wire

//--- source/branch_predecode.sv
`default_nettype none

module branch_predecode (
    fetch_slot_if.predecode slot
);
    import mips_isa_pkg::*;

    opcode_t   opcode;
    reg_t      rt;
    funct_t    funct;
    br_class_t br_class;

    assign opcode = slot.inst[31:26];
    assign rt     = slot.inst[20:16];
    assign funct  = slot.inst[5:0];

    always_comb begin
        br_class = none;
        case (opcode)
            BEQ, BNE, BLEZ, BGTZ: begin
                br_class = cond_branch;
            end
            REGIMM: begin
                if (rt == BLTZ || rt == BGEZ || rt == BLTZAL || rt == BGEZAL) begin
                    br_class = cond_branch;
                end
            end
            J, JAL: begin
                br_class = jump;
            end
            SPECIAL: begin
                if (funct == JR || funct == JALR) begin
                    br_class = jump_reg;
                end
            end
            default: begin
                br_class = none;
            end
        endcase
    end

    // Every control transfer in MIPS32 carries one delay slot
    assign slot.br_op = br_class != none;

endmodule

`default_nettype wire

//--- source/issue_select.sv
`default_nettype none

`include "fetch_settings.svh"

module issue_select (
    input  logic                        decode_allowin,
    fetch_slot_if.select                slot0,
    fetch_slot_if.select                slot1,
    output fetch_types_pkg::issue_num_t pop_num,
    output logic                        out0_valid,
    output logic                        out1_valid,
    output fetch_types_pkg::word_t      out0_inst,
    output fetch_types_pkg::word_t      out1_inst,
    output fetch_types_pkg::pc_t        out0_pc,
    output fetch_types_pkg::pc_t        out1_pc
);
    import fetch_types_pkg::*;

    issue_num_t send_num;

    ////////////////////////////////////////
    // Issue rule
    ////////////////////////////////////////

    // A branch and its delay slot always leave together
    always_comb begin
        if (!slot0.present) begin
            send_num = issue_num_t'(0);
        end else if (!slot1.present) begin
            // Lone branch waits for its delay slot
            if (slot0.br_op) begin
                send_num = issue_num_t'(0);
            end else begin
                send_num = issue_num_t'(1);
            end
        end else if (slot1.br_op) begin
            // Hold a second-slot branch back for the next cycle
            send_num = issue_num_t'(1);
        end else begin
            send_num = issue_num_t'(`FETCH_ISSUE_WIDTH);
        end
    end

    // Decode takes whatever is valid in the same cycle
    assign pop_num = decode_allowin ? send_num : issue_num_t'(0);

    assign out0_valid = pop_num != issue_num_t'(0);
    assign out1_valid = pop_num == issue_num_t'(2);

    assign out0_inst = slot0.inst;
    assign out0_pc   = slot0.pc;
    assign out1_inst = slot1.inst;
    assign out1_pc   = slot1.pc;

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`default_nettype none

`include "fetch_settings.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,

    // Instruction cache side
    input  logic                   line_valid,
    input  fetch_types_pkg::pc_t   line_pc,
    input  fetch_types_pkg::line_t line_data,
    output logic                   line_ready,

    // Decode side
    input  logic                   decode_allowin,
    output logic                   out0_valid,
    output fetch_types_pkg::word_t out0_inst,
    output fetch_types_pkg::pc_t   out0_pc,
    output logic                   out1_valid,
    output fetch_types_pkg::word_t out1_inst,
    output fetch_types_pkg::pc_t   out1_pc
);
    import fetch_types_pkg::*;

    issue_num_t pop_num;

    // One interface per head slot of the queue
    fetch_slot_if slot [`FETCH_ISSUE_WIDTH] ();

    ////////////////////////////////////////
    // Instruction queue
    ////////////////////////////////////////

    fetch_queue u_queue (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .line_valid (line_valid),
        .line_pc    (line_pc),
        .line_data  (line_data),
        .line_ready (line_ready),
        .pop_num    (pop_num),
        .slot0      (slot[0]),
        .slot1      (slot[1])
    );

    ////////////////////////////////////////
    // Predecode of the head entries
    ////////////////////////////////////////

    for (genvar g = 0; g < `FETCH_ISSUE_WIDTH; g++) begin : g_predecode
        branch_predecode u_predecode (
            .slot (slot[g])
        );
    end

    ////////////////////////////////////////
    // Issue to decode
    ////////////////////////////////////////

    issue_select u_select (
        .decode_allowin (decode_allowin),
        .slot0          (slot[0]),
        .slot1          (slot[1]),
        .pop_num        (pop_num),
        .out0_valid     (out0_valid),
        .out1_valid     (out1_valid),
        .out0_inst      (out0_inst),
        .out1_inst      (out1_inst),
        .out0_pc        (out0_pc),
        .out1_pc        (out1_pc)
    );

endmodule

`default_nettype wire

//--- tb/fetch_unit_tb.sv
`default_nettype none

`include "fetch_settings.svh"

module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_types_pkg::*;

    localparam int depth          = `FETCH_QUEUE_DEPTH;
    localparam int line_words     = `FETCH_LINE_WORDS;
    localparam int random_lines   = 200;
    localparam int directed_lines = 30;
    localparam int timeout_cycles = (random_lines + directed_lines) * 40 + 200;

    logic  clk;
    logic  reset;
    logic  flush;
    logic  line_valid;
    pc_t   line_pc;
    line_t line_data;
    logic  line_ready;
    logic  decode_allowin;
    logic  out0_valid;
    word_t out0_inst;
    pc_t   out0_pc;
    logic  out1_valid;
    word_t out1_inst;
    pc_t   out1_pc;

    integer seed = 32'h5e8420bb;
    int     valid_errors = 0;
    int     data_errors = 0;
    int     ready_errors = 0;
    logic   random_allowin;

    // Reference queue kept only from the DUT inputs
    word_t      m_inst [depth];
    pc_t        m_pc   [depth];
    int         m_head;
    int         m_count;
    logic [1:0] raw_send;
    logic [1:0] exp_send;
    logic       exp_valid0;
    logic       exp_valid1;
    logic       exp_ready;
    logic       exp_present0;
    logic       exp_present1;
    word_t      exp_inst0;
    word_t      exp_inst1;
    pc_t        exp_pc0;
    pc_t        exp_pc1;

    fetch_unit uut (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .line_valid     (line_valid),
        .line_pc        (line_pc),
        .line_data      (line_data),
        .line_ready     (line_ready),
        .decode_allowin (decode_allowin),
        .out0_valid     (out0_valid),
        .out0_inst      (out0_inst),
        .out0_pc        (out0_pc),
        .out1_valid     (out1_valid),
        .out1_inst      (out1_inst),
        .out1_pc        (out1_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Branches, jumps and register jumps all have a delay slot
    function automatic logic has_delay_slot(word_t w);
        logic [5:0] op;
        logic [4:0] rt;
        logic [5:0] fn;
        op = w[31:26];
        rt = w[20:16];
        fn = w[5:0];
        if (op >= 6'd2 && op <= 6'd7) return 1'b1;
        if (op == 6'd1) return rt == 5'd0 || rt == 5'd1 || rt == 5'd16 || rt == 5'd17;
        if (op == 6'd0) return fn == 6'd8 || fn == 6'd9;
        return 1'b0;
    endfunction

    always_comb begin
        exp_present0 = m_count >= 1;
        exp_present1 = m_count >= 2;
        exp_inst0    = m_inst[m_head];
        exp_pc0      = m_pc[m_head];
        exp_inst1    = m_inst[(m_head + 1) % depth];
        exp_pc1      = m_pc[(m_head + 1) % depth];
        if (m_count == 0) begin
            raw_send = 2'd0;
        end else if (m_count == 1) begin
            raw_send = has_delay_slot(exp_inst0) ? 2'd0 : 2'd1;
        end else if (has_delay_slot(exp_inst1)) begin
            raw_send = 2'd1;
        end else begin
            raw_send = 2'd2;
        end
        exp_send   = decode_allowin ? raw_send : 2'd0;
        exp_valid0 = exp_send != 2'd0;
        exp_valid1 = exp_send == 2'd2;
        // A whole line needs that many free entries
        exp_ready  = depth - m_count >= line_words;
    end

    always @(posedge clk) begin
        int tail;
        int first;
        int num;
        if (reset || flush) begin
            m_head  <= 0;
            m_count <= 0;
        end else begin
            num = 0;
            if (line_valid && exp_ready) begin
                tail  = (m_head + m_count) % depth;
                first = int'(line_pc[3:2]);
                num   = line_words - first;
                for (int i = 0; i < num; i++) begin
                    m_inst[(tail + i) % depth] <= word_t'(line_data >> (32 * (first + i)));
                    m_pc[(tail + i) % depth]   <= {line_pc[31:4], 4'b0000} + pc_t'(4 * (first + i));
                end
            end
            m_head  <= (m_head + int'(exp_send)) % depth;
            m_count <= m_count + num - int'(exp_send);
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        $display("MISMATCH %s: got %h, expected %h at %0t", name, got, expected, $time);
    endtask

    a_valid0: assert property (@(posedge clk) disable iff (reset) out0_valid == exp_valid0)
        else begin
            valid_errors++;
            show_mismatch("out0_valid", 32'($sampled(out0_valid)), 32'($sampled(exp_valid0)));
        end
    a_valid1: assert property (@(posedge clk) disable iff (reset) out1_valid == exp_valid1)
        else begin
            valid_errors++;
            show_mismatch("out1_valid", 32'($sampled(out1_valid)), 32'($sampled(exp_valid1)));
        end
    a_ready: assert property (@(posedge clk) disable iff (reset) line_ready == exp_ready)
        else begin
            ready_errors++;
            show_mismatch("line_ready", 32'($sampled(line_ready)), 32'($sampled(exp_ready)));
        end
    // Head data is compared whenever the slot holds an entry, so stalls must hold it steady
    a_inst0: assert property (@(posedge clk) disable iff (reset)
                              exp_present0 |-> out0_inst == exp_inst0)
        else begin
            data_errors++;
            show_mismatch("out0_inst", $sampled(out0_inst), $sampled(exp_inst0));
        end
    a_pc0: assert property (@(posedge clk) disable iff (reset)
                            exp_present0 |-> out0_pc == exp_pc0)
        else begin
            data_errors++;
            show_mismatch("out0_pc", $sampled(out0_pc), $sampled(exp_pc0));
        end
    a_inst1: assert property (@(posedge clk) disable iff (reset)
                              exp_present1 |-> out1_inst == exp_inst1)
        else begin
            data_errors++;
            show_mismatch("out1_inst", $sampled(out1_inst), $sampled(exp_inst1));
        end
    a_pc1: assert property (@(posedge clk) disable iff (reset)
                            exp_present1 |-> out1_pc == exp_pc1)
        else begin
            data_errors++;
            show_mismatch("out1_pc", $sampled(out1_pc), $sampled(exp_pc1));
        end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    task automatic next_random(output word_t r);
        r = $random(seed);
    endtask

    // ADDIU with random fields never transfers control
    task automatic make_plain(output word_t w);
        word_t r;
        next_random(r);
        w = {6'b001001, r[25:0]};
    endtask

    task automatic make_branch(input int kind, output word_t w);
        word_t r;
        next_random(r);
        case (kind)
            0:       w = {6'b000100, r[25:0]};
            1:       w = {6'b000010, r[25:0]};
            2:       w = {6'b000000, r[25:6], 6'b001000};
            default: w = {6'b000001, r[25:21], 5'b10001, r[15:0]};
        endcase
    endtask

    task automatic random_line(output line_t l);
        word_t w [4];
        for (int i = 0; i < 4; i++) begin
            next_random(w[i]);
        end
        l = {w[3], w[2], w[1], w[0]};
    endtask

    task automatic plain_line(output line_t l);
        word_t w [4];
        for (int i = 0; i < 4; i++) begin
            make_plain(w[i]);
        end
        l = {w[3], w[2], w[1], w[0]};
    endtask

    // Called at a falling edge; returns at the falling edge after the line is taken
    task automatic send_line(input pc_t pc, input line_t data);
        line_valid = 1'b1;
        line_pc    = pc;
        line_data  = data;
        while (!line_ready) @(negedge clk);
        @(negedge clk);
        line_valid = 1'b0;
    endtask

    // Offers a line while the queue has no room for it, then lets decode drain it
    task automatic offer_while_blocked(input pc_t pc, input line_t data, input int hold);
        line_valid = 1'b1;
        line_pc    = pc;
        line_data  = data;
        repeat (hold) @(negedge clk);
        decode_allowin = 1'b1;
        while (!line_ready) @(negedge clk);
        @(negedge clk);
        line_valid = 1'b0;
    endtask

    // The line offered together with the flush must be ignored
    task automatic flush_queue();
        line_t l;
        random_line(l);
        line_valid = 1'b1;
        line_pc    = 32'h00bf_0000;
        line_data  = l;
        flush      = 1'b1;
        @(negedge clk);
        flush      = 1'b0;
        line_valid = 1'b0;
    endtask

    task automatic drain();
        decode_allowin = 1'b1;
        while (raw_send != 2'd0) @(negedge clk);
        flush_queue();
    endtask

    initial begin
        word_t r;
        forever begin
            @(negedge clk);
            if (random_allowin) begin
                next_random(r);
                decode_allowin = r[0];
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        line_t l;
        pc_t   pc;
        word_t r;
        word_t w0;
        word_t w1;
        word_t w2;
        word_t w3;
        reset          = 1'b1;
        flush          = 1'b0;
        line_valid     = 1'b0;
        line_pc        = '0;
        line_data      = '0;
        decode_allowin = 1'b0;
        random_allowin = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        // Every word offset over several rounds so both pointers wrap
        decode_allowin = 1'b1;
        pc = 32'h0040_0000;
        for (int round = 0; round < 3; round++) begin
            for (int k = 0; k < 4; k++) begin
                plain_line(l);
                send_line(pc + pc_t'(4 * k), l);
                pc = pc + 32'd16;
            end
        end
        drain();

        // Branch in slot 1, then branch and delay slot together
        decode_allowin = 1'b0;
        make_plain(w0);
        make_branch(0, w1);
        make_plain(w2);
        make_plain(w3);
        send_line(pc, {w3, w2, w1, w0});
        pc = pc + 32'd16;
        drain();

        // Lone jump at the last word waits for the next line
        decode_allowin = 1'b1;
        make_branch(1, w3);
        send_line(pc + 32'd12, {w3, w2, w1, w0});
        pc = pc + 32'd16;
        repeat (4) @(negedge clk);
        plain_line(l);
        send_line(pc, l);
        pc = pc + 32'd16;
        drain();

        make_plain(w0);
        make_branch(2, w1);
        make_plain(w2);
        make_branch(3, w3);
        send_line(pc, {w3, w2, w1, w0});
        pc = pc + 32'd16;
        repeat (3) @(negedge clk);
        plain_line(l);
        send_line(pc, l);
        pc = pc + 32'd16;
        drain();

        // Stall until line_ready falls, then release decode
        decode_allowin = 1'b0;
        plain_line(l);
        send_line(pc + 32'd4, l);
        pc = pc + 32'd16;
        plain_line(l);
        send_line(pc, l);
        pc = pc + 32'd16;
        plain_line(l);
        offer_while_blocked(pc, l, 6);
        pc = pc + 32'd16;
        drain();

        // Flush in the middle of a stream
        decode_allowin = 1'b0;
        plain_line(l);
        send_line(pc, l);
        pc = pc + 32'd16;
        random_line(l);
        send_line(pc + 32'd8, l);
        pc = pc + 32'd16;
        decode_allowin = 1'b1;
        @(negedge clk);
        flush_queue();
        pc = 32'h0080_0000;
        random_line(l);
        send_line(pc + 32'd4, l);
        pc = pc + 32'd16;
        drain();

        // Long random stream with random stalls and offsets
        random_allowin = 1'b1;
        for (int n = 0; n < random_lines; n++) begin
            next_random(r);
            random_line(l);
            send_line(pc + pc_t'({r[1:0], 2'b00}), l);
            pc = pc + 32'd16;
        end
        random_allowin = 1'b0;
        @(negedge clk);
        drain();
        repeat (4) @(negedge clk);

        $display("Errors: valid %0d, data %0d, line_ready %0d",
                 valid_errors, data_errors, ready_errors);
        if (valid_errors + data_errors + ready_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
source/fetch_types_pkg.sv
source/mips_isa_pkg.sv
source/fetch_slot_if.sv
source/fetch_queue.sv
source/branch_predecode.sv
source/issue_select.sv
source/fetch_unit.sv
tb/fetch_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the fetch unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/fetch_unit_tb_sim

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module fetch_unit_tb \
    --Mdir obj_dir \
    -o fetch_unit_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./$SIM > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
